// File: mem_bus_pkg.sv
// shared message types, header and beat structs for the memory to wishbone bridge
`default_nettype none

package mem_bus_pkg;

  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 64;
  localparam int BYTES_PER_WORD  = DATA_WIDTH / 8;
  localparam int LANE_BITS       = $clog2(BYTES_PER_WORD);
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - LANE_BITS;

  // only uncached traffic is carried
  typedef enum logic [1:0] {
    MSG_UC_RD = 2'b00,
    MSG_UC_WR = 2'b01
  } mem_msg_type_e;

  // log2 of the byte count
  typedef enum logic [2:0] {
    SIZE_1  = 3'd0,
    SIZE_2  = 3'd1,
    SIZE_4  = 3'd2,
    SIZE_8  = 3'd3,
    SIZE_16 = 3'd4,
    SIZE_32 = 3'd5
  } mem_msg_size_e;

  typedef struct packed {
    mem_msg_type_e           msg_type;
    mem_msg_size_e           size;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [7:0]              id;
  } mem_header_s;

  // one bus word on its way to the wishbone master
  typedef struct packed {
    logic [WORD_ADDR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0]      data;
    logic [BYTES_PER_WORD-1:0]  sel;
    logic                       we;
    logic                       last;
    mem_msg_size_e              size;
  } bus_req_s;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } bus_resp_s;

  // copies the low bytes of a narrow access into every lane
  function automatic logic [DATA_WIDTH-1:0] replicate_low(
    input logic [DATA_WIDTH-1:0] data,
    input mem_msg_size_e         size
  );
    logic [DATA_WIDTH-1:0] rep;
    case (size)
      SIZE_1:  rep = {(BYTES_PER_WORD){data[7:0]}};
      SIZE_2:  rep = {(BYTES_PER_WORD / 2){data[15:0]}};
      SIZE_4:  rep = {(BYTES_PER_WORD / 4){data[31:0]}};
      default: rep = data;
    endcase
    return rep;
  endfunction

endpackage

`default_nettype wire

// File: cmd_stream_in.sv
// command stream input side, turns header and data beats into bus-word requests
`timescale 1ns/1ps
`default_nettype none

module cmd_stream_in
  import mem_bus_pkg::*;
#(
  parameter int MAX_BEATS = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire mem_header_s           cmd_header_i,
  input  wire logic [DATA_WIDTH-1:0] cmd_data_i,
  input  wire logic                  cmd_v_i,
  input  wire logic                  cmd_last_i,
  output logic                       cmd_ready_and_o,
  output bus_req_s                   req_o,
  output logic                       req_v_o,
  input  wire logic                  req_yumi_i,
  output mem_header_s                hdr_o
);

  localparam int CNT_W = $clog2(MAX_BEATS + 1);

  mem_header_s       hdr_r;
  logic              first_r;
  logic [CNT_W-1:0]  cnt_r;
  bus_req_s          req_r;
  logic              req_v_r;

  logic              accept;
  logic              rd_next;
  logic              load_req;
  mem_header_s       src_hdr;
  logic [CNT_W-1:0]  src_idx;
  logic [CNT_W-1:0]  total;
  bus_req_s          next_req;

  // words in the command, never more than MAX_BEATS
  function automatic logic [CNT_W-1:0] beat_total(input mem_msg_size_e size);
    int beats;
    beats = (size > SIZE_8) ? (1 << (int'(size) - int'(SIZE_8))) : 1;
    if (beats > MAX_BEATS) begin
      beats = MAX_BEATS;
    end
    return CNT_W'(beats);
  endfunction

  function automatic logic [BYTES_PER_WORD-1:0] lane_sel(input mem_header_s h);
    logic [BYTES_PER_WORD-1:0] mask;
    case (h.size)
      SIZE_1:  mask = BYTES_PER_WORD'(8'h01);
      SIZE_2:  mask = BYTES_PER_WORD'(8'h03);
      SIZE_4:  mask = BYTES_PER_WORD'(8'h0f);
      default: mask = '1;
    endcase
    if (h.size < SIZE_8) begin
      mask = mask << h.addr[LANE_BITS-1:0];
    end
    return mask;
  endfunction

  assign accept  = cmd_v_i & cmd_ready_and_o;
  // reads expand into further words from the held header
  assign rd_next = req_yumi_i & ~req_r.we & ~req_r.last;
  assign load_req = accept | rd_next;

  always_comb begin
    if (accept && first_r) begin
      src_hdr = cmd_header_i;
      src_idx = '0;
    end else begin
      src_hdr = hdr_r;
      src_idx = cnt_r;
    end
    total = beat_total(src_hdr.size);

    next_req.adr  = src_hdr.addr[ADDR_WIDTH-1:LANE_BITS] + WORD_ADDR_WIDTH'(src_idx);
    next_req.sel  = lane_sel(src_hdr);
    next_req.we   = (src_hdr.msg_type == MSG_UC_WR);
    next_req.last = ((src_idx + CNT_W'(1)) == total);
    next_req.size = src_hdr.size;
    // narrow write data is taken from the low bytes
    next_req.data = next_req.we ? replicate_low(cmd_data_i, src_hdr.size) : '0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_v_r <= 1'b0;
      first_r <= 1'b1;
      cnt_r   <= '0;
    end else if (accept) begin
      req_v_r <= 1'b1;
      first_r <= cmd_last_i;
      cnt_r   <= src_idx + CNT_W'(1);
    end else if (req_yumi_i) begin
      req_v_r <= rd_next;
      if (rd_next) begin
        cnt_r <= cnt_r + CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && first_r) begin
      hdr_r <= cmd_header_i;
    end
    if (load_req) begin
      req_r <= next_req;
    end
  end

  assign cmd_ready_and_o = ~req_v_r;
  assign req_o           = req_r;
  assign req_v_o         = req_v_r;
  assign hdr_o           = hdr_r;

endmodule

`default_nettype wire

// File: wb_master_fsm.sv
// wishbone classic master, one bus cycle per request with registered cyc and stb
`timescale 1ns/1ps
`default_nettype none

module wb_master_fsm
  import mem_bus_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  input  wire bus_req_s                   req_i,
  input  wire logic                       req_v_i,
  output logic                            req_yumi_o,
  input  wire logic                       resp_room_i,
  output bus_resp_s                       resp_o,
  output logic                            resp_v_o,
  output logic [WORD_ADDR_WIDTH-1:0]      wb_adr_o,
  output logic [DATA_WIDTH-1:0]           wb_dat_o,
  output logic [BYTES_PER_WORD-1:0]       wb_sel_o,
  output logic                            wb_we_o,
  output logic                            wb_cyc_o,
  output logic                            wb_stb_o,
  input  wire logic [DATA_WIDTH-1:0]      wb_dat_i,
  input  wire logic                       wb_ack_i
);

  typedef enum logic [1:0] {
    ST_RESET    = 2'b00,
    ST_WAIT_REQ = 2'b01,
    ST_WAIT_ACK = 2'b10
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   cyc_n;
  logic   stb_n;
  logic   start;
  logic   done;

  // only start when the output register can take the beat
  assign start = req_v_i & resp_room_i;
  assign done  = (state_r == ST_WAIT_ACK) & wb_ack_i;

  always_comb begin
    state_n = state_r;
    cyc_n   = 1'b0;
    stb_n   = 1'b0;
    case (state_r)
      ST_RESET: begin
        state_n = ST_WAIT_REQ;
      end
      ST_WAIT_REQ: begin
        cyc_n = start;
        stb_n = start;
        if (start) begin
          state_n = ST_WAIT_ACK;
        end
      end
      ST_WAIT_ACK: begin
        // drop the strobe the cycle after ack
        cyc_n = ~wb_ack_i;
        stb_n = ~wb_ack_i;
        if (wb_ack_i) begin
          state_n = ST_WAIT_REQ;
        end
      end
      default: begin
        state_n = ST_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r  <= ST_RESET;
      wb_cyc_o <= 1'b0;
      wb_stb_o <= 1'b0;
    end else begin
      state_r  <= state_n;
      wb_cyc_o <= cyc_n;
      wb_stb_o <= stb_n;
    end
  end

  // request is held stable until it is consumed
  assign wb_adr_o = req_i.adr;
  assign wb_dat_o = req_i.data;
  assign wb_sel_o = req_i.sel;
  assign wb_we_o  = req_i.we;

  assign req_yumi_o  = done;
  assign resp_v_o    = done;
  assign resp_o.data = wb_dat_i;
  assign resp_o.last = req_i.last;

endmodule

`default_nettype wire

// File: resp_stream_out.sv
// response stream output side, one-entry register with narrow read replication
`timescale 1ns/1ps
`default_nettype none

module resp_stream_out
  import mem_bus_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire mem_header_s           hdr_i,
  input  wire bus_resp_s             beat_i,
  input  wire logic                  beat_v_i,
  output logic                       room_o,
  output mem_header_s                resp_header_o,
  output logic [DATA_WIDTH-1:0]      resp_data_o,
  output logic                       resp_v_o,
  output logic                       resp_last_o,
  input  wire logic                  resp_ready_and_i
);

  mem_header_s           hdr_r;
  logic [DATA_WIDTH-1:0] data_r;
  logic                  last_r;
  logic                  v_r;

  logic                  narrow;
  logic [DATA_WIDTH-1:0] lane_data;
  logic [DATA_WIDTH-1:0] beat_data;

  assign narrow = (hdr_i.size < SIZE_8);

  always_comb begin
    // move the addressed lanes down to byte zero, then fan out
    lane_data = beat_i.data >> {hdr_i.addr[LANE_BITS-1:0], 3'b000};
    if (narrow) begin
      beat_data = replicate_low(lane_data, hdr_i.size);
    end else begin
      beat_data = beat_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      v_r <= 1'b0;
    end else if (beat_v_i) begin
      v_r <= 1'b1;
    end else if (resp_ready_and_i) begin
      v_r <= 1'b0;
    end
  end

  // header copy kept here, the input side moves on to the next command
  always_ff @(posedge clk_i) begin
    if (beat_v_i) begin
      hdr_r  <= hdr_i;
      data_r <= beat_data;
      last_r <= beat_i.last;
    end
  end

  // free only when empty, so an ack never meets a full register
  assign room_o = ~v_r;

  assign resp_header_o = hdr_r;
  assign resp_data_o   = data_r;
  assign resp_v_o      = v_r;
  assign resp_last_o   = last_r;

endmodule

`default_nettype wire

// File: wb_sram_slave.sv
// wishbone classic target memory with byte selects and one wait state
`timescale 1ns/1ps
`default_nettype none

module wb_sram_slave
  import mem_bus_pkg::*;
#(
  parameter int SRAM_WORDS = 256
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  input  wire logic [WORD_ADDR_WIDTH-1:0] wb_adr_i,
  input  wire logic [DATA_WIDTH-1:0]      wb_dat_i,
  input  wire logic [BYTES_PER_WORD-1:0]  wb_sel_i,
  input  wire logic                       wb_we_i,
  input  wire logic                       wb_cyc_i,
  input  wire logic                       wb_stb_i,
  output logic [DATA_WIDTH-1:0]           wb_dat_o,
  output logic                            wb_ack_o
);

  localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

  logic [DATA_WIDTH-1:0] mem [SRAM_WORDS];
  logic [IDX_W-1:0]      idx;
  logic                  take;
  logic                  ack_r;

  // address wraps around the memory depth
  assign idx  = IDX_W'(wb_adr_i % SRAM_WORDS);
  // serve once per bus cycle, ack blocks a second take
  assign take = wb_cyc_i & wb_stb_i & ~ack_r;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_r <= 1'b0;
    end else begin
      ack_r <= take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && wb_we_i) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (wb_sel_i[b]) begin
          mem[idx][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
        end
      end
    end
    // read data lines up with ack
    if (take) begin
      wb_dat_o <= mem[idx];
    end
  end

  assign wb_ack_o = ack_r;

endmodule

`default_nettype wire

// File: mem_wb_bridge_top.sv
// memory command stream to wishbone bridge with its local sram target
`timescale 1ns/1ps
`default_nettype none

module mem_wb_bridge_top
  import mem_bus_pkg::*;
#(
  parameter int SRAM_WORDS = 256,
  parameter int MAX_BEATS  = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire mem_header_s           cmd_header_i,
  input  wire logic [DATA_WIDTH-1:0] cmd_data_i,
  input  wire logic                  cmd_v_i,
  input  wire logic                  cmd_last_i,
  output logic                       cmd_ready_and_o,
  output mem_header_s                resp_header_o,
  output logic [DATA_WIDTH-1:0]      resp_data_o,
  output logic                       resp_v_o,
  output logic                       resp_last_o,
  input  wire logic                  resp_ready_and_i
);

  bus_req_s                   req;
  logic                       req_v;
  logic                       req_yumi;
  mem_header_s                hdr;
  bus_resp_s                  beat;
  logic                       beat_v;
  logic                       room;

  logic [WORD_ADDR_WIDTH-1:0] wb_adr;
  logic [DATA_WIDTH-1:0]      wb_dat_w;
  logic [DATA_WIDTH-1:0]      wb_dat_r;
  logic [BYTES_PER_WORD-1:0]  wb_sel;
  logic                       wb_we;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_ack;

  cmd_stream_in #(
    .MAX_BEATS(MAX_BEATS)
  ) u_cmd_in (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd_header_i   (cmd_header_i),
    .cmd_data_i     (cmd_data_i),
    .cmd_v_i        (cmd_v_i),
    .cmd_last_i     (cmd_last_i),
    .cmd_ready_and_o(cmd_ready_and_o),
    .req_o          (req),
    .req_v_o        (req_v),
    .req_yumi_i     (req_yumi),
    .hdr_o          (hdr)
  );

  wb_master_fsm u_master (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req),
    .req_v_i    (req_v),
    .req_yumi_o (req_yumi),
    .resp_room_i(room),
    .resp_o     (beat),
    .resp_v_o   (beat_v),
    .wb_adr_o   (wb_adr),
    .wb_dat_o   (wb_dat_w),
    .wb_sel_o   (wb_sel),
    .wb_we_o    (wb_we),
    .wb_cyc_o   (wb_cyc),
    .wb_stb_o   (wb_stb),
    .wb_dat_i   (wb_dat_r),
    .wb_ack_i   (wb_ack)
  );

  resp_stream_out u_resp_out (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .hdr_i           (hdr),
    .beat_i          (beat),
    .beat_v_i        (beat_v),
    .room_o          (room),
    .resp_header_o   (resp_header_o),
    .resp_data_o     (resp_data_o),
    .resp_v_o        (resp_v_o),
    .resp_last_o     (resp_last_o),
    .resp_ready_and_i(resp_ready_and_i)
  );

  wb_sram_slave #(
    .SRAM_WORDS(SRAM_WORDS)
  ) u_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w),
    .wb_sel_i(wb_sel),
    .wb_we_i (wb_we),
    .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb),
    .wb_dat_o(wb_dat_r),
    .wb_ack_o(wb_ack)
  );

endmodule

`default_nettype wire

// File: tb_mem_wb_bridge.sv
// table driven testbench for the memory command stream to wishbone bridge with a byte model
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb_bridge
  import mem_bus_pkg::*;
();

  localparam int SRAM_WORDS = 256;
  localparam int MAX_BEATS  = 4;
  localparam int TIMEOUT    = 200;

  // one command of the table with its random data and response expectations
  typedef struct packed {
    mem_msg_type_e     msg_type;
    mem_msg_size_e     size;
    logic [31:0]       addr;
    logic [7:0]        id;
    logic [3:0][63:0]  data;
    logic [3:0]        stall;
    logic [2:0]        beats;
  } cmd_entry_s;

  logic                  clk = 1'b0;
  logic                  rst_n;
  mem_header_s           cmd_header;
  logic [DATA_WIDTH-1:0] cmd_data;
  logic                  cmd_v;
  logic                  cmd_last;
  logic                  cmd_ready;
  mem_header_s           resp_header;
  logic [DATA_WIDTH-1:0] resp_data;
  logic                  resp_v;
  logic                  resp_last;
  logic                  resp_ready;

  cmd_entry_s            cmd_table [$];
  logic [7:0]            ref_mem [SRAM_WORDS*8];
  integer                seed;
  int                    next_id;
  logic                  saw_drop;

  mem_wb_bridge_top #(
    .SRAM_WORDS(SRAM_WORDS),
    .MAX_BEATS (MAX_BEATS)
  ) UUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .cmd_header_i    (cmd_header),
    .cmd_data_i      (cmd_data),
    .cmd_v_i         (cmd_v),
    .cmd_last_i      (cmd_last),
    .cmd_ready_and_o (cmd_ready),
    .resp_header_o   (resp_header),
    .resp_data_o     (resp_data),
    .resp_v_o        (resp_v),
    .resp_last_o     (resp_last),
    .resp_ready_and_i(resp_ready)
  );

  always #10 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic add_cmd(input mem_msg_type_e t, input mem_msg_size_e s,
                         input logic [31:0] a, input int beats, input int stall);
    cmd_entry_s e;
    e.msg_type = t;
    e.size     = s;
    e.addr     = a;
    e.id       = 8'(next_id);
    next_id++;
    for (int k = 0; k < 4; k++) begin
      e.data[k] = {$random(seed), $random(seed)};
    end
    e.beats = 3'(beats);
    e.stall = 4'(stall);
    cmd_table.push_back(e);
  endtask

  task automatic build_table();
    // full words first so that narrow accesses never touch unwritten bytes
    add_cmd(MSG_UC_WR, SIZE_8,  32'h100, 1, 0);
    add_cmd(MSG_UC_WR, SIZE_8,  32'h108, 1, 0);
    add_cmd(MSG_UC_RD, SIZE_8,  32'h100, 1, 0);
    add_cmd(MSG_UC_RD, SIZE_8,  32'h108, 1, 0);
    add_cmd(MSG_UC_WR, SIZE_1,  32'h103, 1, 0);
    add_cmd(MSG_UC_WR, SIZE_2,  32'h10a, 1, 0);
    add_cmd(MSG_UC_WR, SIZE_4,  32'h104, 1, 0);
    add_cmd(MSG_UC_RD, SIZE_1,  32'h103, 1, 0);
    add_cmd(MSG_UC_RD, SIZE_2,  32'h10a, 1, 0);
    add_cmd(MSG_UC_RD, SIZE_4,  32'h104, 1, 0);
    add_cmd(MSG_UC_RD, SIZE_1,  32'h107, 1, 0);
    add_cmd(MSG_UC_RD, SIZE_8,  32'h100, 1, 0);
    add_cmd(MSG_UC_RD, SIZE_8,  32'h108, 1, 0);
    add_cmd(MSG_UC_WR, SIZE_16, 32'h200, 2, 0);
    add_cmd(MSG_UC_WR, SIZE_32, 32'h300, 4, 0);
    add_cmd(MSG_UC_RD, SIZE_16, 32'h200, 2, 0);
    add_cmd(MSG_UC_RD, SIZE_32, 32'h300, 4, 0);
    // back-pressure on the response side
    add_cmd(MSG_UC_WR, SIZE_32, 32'h400, 4, 5);
    add_cmd(MSG_UC_RD, SIZE_32, 32'h400, 4, 5);
    add_cmd(MSG_UC_WR, SIZE_16, 32'h200, 2, 6);
    add_cmd(MSG_UC_RD, SIZE_2,  32'h206, 1, 4);
    add_cmd(MSG_UC_RD, SIZE_16, 32'h200, 2, 3);
  endtask

  // narrow writes land on the addressed bytes, wide ones fill whole words
  task automatic model_write(input cmd_entry_s e);
    int n;
    n = 1 << int'(e.size);
    if (n < BYTES_PER_WORD) begin
      for (int i = 0; i < n; i++) begin
        ref_mem[int'(e.addr) + i] = e.data[0][i*8 +: 8];
      end
    end else begin
      for (int k = 0; k < int'(e.beats); k++) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
          ref_mem[int'(e.addr) + k*8 + b] = e.data[k][b*8 +: 8];
        end
      end
    end
  endtask

  function automatic logic [63:0] expect_word(input cmd_entry_s e, input int k);
    logic [63:0] w;
    int          n;
    n = 1 << int'(e.size);
    for (int b = 0; b < BYTES_PER_WORD; b++) begin
      if (n < BYTES_PER_WORD) begin
        w[b*8 +: 8] = ref_mem[int'(e.addr) + (b % n)];
      end else begin
        w[b*8 +: 8] = ref_mem[int'(e.addr) + k*8 + b];
      end
    end
    return w;
  endfunction

  task automatic send_cmd(input cmd_entry_s e);
    int nb;
    int t;
    nb = (e.msg_type == MSG_UC_WR) ? int'(e.beats) : 1;
    for (int k = 0; k < nb; k++) begin
      cmd_header.msg_type = e.msg_type;
      cmd_header.size     = e.size;
      cmd_header.addr     = e.addr;
      cmd_header.id       = e.id;
      cmd_data            = e.data[k];
      cmd_last            = (k == nb - 1);
      cmd_v               = 1'b1;
      t = 0;
      while (!cmd_ready) begin
        @(negedge clk);
        t++;
        if (t > TIMEOUT) begin
          fail_now("timeout waiting for cmd_ready_and_o to accept a command beat");
        end
      end
      @(negedge clk);
    end
    cmd_v    = 1'b0;
    cmd_last = 1'b0;
  endtask

  task automatic recv_resp(input cmd_entry_s e);
    int          t;
    mem_header_s exp_hdr;
    logic [63:0] exp_data;
    exp_hdr.msg_type = e.msg_type;
    exp_hdr.size     = e.size;
    exp_hdr.addr     = e.addr;
    exp_hdr.id       = e.id;
    for (int k = 0; k < int'(e.beats); k++) begin
      resp_ready = (e.stall == 0);
      t = 0;
      while (!resp_v) begin
        @(negedge clk);
        t++;
        if (t > TIMEOUT) begin
          fail_now("timeout waiting for resp_v_o on a response beat");
        end
      end
      // hold the full output register and watch the command side back off
      for (int s = 0; s < int'(e.stall); s++) begin
        if (!cmd_ready) begin
          saw_drop = 1'b1;
        end
        @(negedge clk);
      end
      resp_ready = 1'b1;
      exp_data   = expect_word(e, k);
      assert (resp_header == exp_hdr) else
        fail_now($sformatf("FAILED at %0t ns: id %0d beat %0d header %h, expected %h",
                           $time, e.id, k, resp_header, exp_hdr));
      assert (resp_last == (k == int'(e.beats) - 1)) else
        fail_now($sformatf("FAILED at %0t ns: id %0d beat %0d last %b",
                           $time, e.id, k, resp_last));
      if (e.msg_type == MSG_UC_RD) begin
        assert (resp_data == exp_data) else
          fail_now($sformatf("FAILED at %0t ns: id %0d beat %0d data %h, expected %h",
                             $time, e.id, k, resp_data, exp_data));
      end
      @(negedge clk);
    end
    resp_ready = 1'b1;
  endtask

  initial begin
    cmd_entry_s e;
    seed       = 66686;
    next_id    = 0;
    saw_drop   = 1'b0;
    rst_n      = 1'b0;
    cmd_header = '0;
    cmd_data   = '0;
    cmd_v      = 1'b0;
    cmd_last   = 1'b0;
    resp_ready = 1'b1;
    build_table();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!resp_v && cmd_ready) else
      fail_now($sformatf("FAILED at %0t ns: after reset resp_v_o %b cmd_ready_and_o %b",
                         $time, resp_v, cmd_ready));

    foreach (cmd_table[i]) begin
      e        = cmd_table[i];
      saw_drop = 1'b0;
      fork
        send_cmd(e);
        recv_resp(e);
      join
      if (e.msg_type == MSG_UC_WR) begin
        model_write(e);
      end
      assert (cmd_ready) else
        fail_now("cmd_ready_and_o did not return high after the command completed");
      if (e.stall != 0 && e.beats > 1) begin
        assert (saw_drop) else
          fail_now("cmd_ready_and_o never dropped while the response output was stalled");
      end
    end

    repeat (5) @(negedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
mem_bus_pkg.sv
cmd_stream_in.sv
wb_master_fsm.sv
resp_stream_out.sv
wb_sram_slave.sv
mem_wb_bridge_top.sv
tb_mem_wb_bridge.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module tb_mem_wb_bridge -o sim_bridge \
  && ./obj_dir/sim_bridge | tee /dev/stderr | grep -q "Verification passed" \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
